//--- Bender.yml
package:
  name: soc_bus

sources:
  - include_dirs:
      - design
    files:
      - design/soc_pkg.sv
      - design/bus_decode.sv
      - design/data_mem.sv
      - design/gpio.sv
      - design/bus_resp_mux.sv
      - design/soc_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/soc_props.sv
      - dv/soc_tb.sv

//--- design/bus_decode.sv
`default_nettype none

`include "soc_cfg.svh"

module bus_decode import soc_pkg::*; (
  input  wire                clock,
  input  wire                arst_n_i,

  input  wire                a_valid_i,
  output logic               a_ready_o,
  input  wire tl_a_op_e      a_opcode_i,
  input  wire [`BUS_AW-1:0]  a_address_i,

  input  wire                rsp_done_i,
  output logic               mem_req_o,
  output logic               gpio_req_o,

  // built-in error responder
  output logic               err_valid_o,
  output tl_d_op_e           err_opcode_o,
  input  wire                d_ready_i
);

  dev_sel_e dev_sel;
  logic     req_fire;
  logic     outstanding_q;

  // window compare, unsigned offset from each base
  always_comb begin
    if ((a_address_i - `MEM_BASE) < `BUS_AW'(`MEM_WORDS * 4)) begin
      dev_sel = DEV_MEM;
    end else if ((a_address_i - `GPIO_BASE) < `BUS_AW'(`GPIO_SPAN)) begin
      dev_sel = DEV_GPIO;
    end else begin
      dev_sel = DEV_NONE;
    end
  end

  // only one transaction in flight
  assign a_ready_o  = ~outstanding_q;
  assign req_fire   = a_valid_i & a_ready_o;
  assign mem_req_o  = req_fire & (dev_sel == DEV_MEM);
  assign gpio_req_o = req_fire & (dev_sel == DEV_GPIO);

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (req_fire) begin
      outstanding_q <= 1'b1;
    end else if (rsp_done_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // error response held until the host takes it
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_valid_o <= 1'b0;
    end else if (req_fire && dev_sel == DEV_NONE) begin
      err_valid_o <= 1'b1;
    end else if (err_valid_o && d_ready_i) begin
      err_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (req_fire && dev_sel == DEV_NONE) begin
      err_opcode_o <= (a_opcode_i == OP_GET) ? OP_ACK_DATA : OP_ACK;
    end
  end

endmodule

`default_nettype wire

//--- design/bus_resp_mux.sv
`default_nettype none

`include "soc_cfg.svh"

module bus_resp_mux import soc_pkg::*; (
  input  wire                mem_valid_i,
  input  wire tl_d_op_e      mem_opcode_i,
  input  wire [`BUS_DW-1:0]  mem_data_i,
  input  wire                mem_error_i,

  input  wire                gpio_valid_i,
  input  wire tl_d_op_e      gpio_opcode_i,
  input  wire [`BUS_DW-1:0]  gpio_data_i,
  input  wire                gpio_error_i,

  input  wire                err_valid_i,
  input  wire tl_d_op_e      err_opcode_i,

  input  wire                d_ready_i,
  output logic               d_valid_o,
  output tl_d_op_e           d_opcode_o,
  output logic [`BUS_DW-1:0] d_data_o,
  output logic               d_error_o,
  output logic               rsp_done_o
);

  // at most one source is valid at a time
  always_comb begin
    d_valid_o  = 1'b0;
    d_opcode_o = OP_ACK;
    d_data_o   = '0;
    d_error_o  = 1'b0;
    if (mem_valid_i) begin
      d_valid_o  = 1'b1;
      d_opcode_o = mem_opcode_i;
      d_data_o   = mem_data_i;
      d_error_o  = mem_error_i;
    end else if (gpio_valid_i) begin
      d_valid_o  = 1'b1;
      d_opcode_o = gpio_opcode_i;
      d_data_o   = gpio_data_i;
      d_error_o  = gpio_error_i;
    end else if (err_valid_i) begin
      // unmapped address, no data
      d_valid_o  = 1'b1;
      d_opcode_o = err_opcode_i;
      d_error_o  = 1'b1;
    end
  end

  assign rsp_done_o = d_valid_o & d_ready_i;

endmodule

`default_nettype wire

//--- design/data_mem.sv
`default_nettype none

`include "soc_cfg.svh"

module data_mem import soc_pkg::*; (
  input  wire                clock,
  input  wire                arst_n_i,

  input  wire                req_i,
  input  wire tl_a_op_e      opcode_i,
  input  wire [`BUS_AW-1:0]  addr_i,
  input  wire [`BUS_DW-1:0]  wdata_i,
  input  wire [`BUS_MW-1:0]  mask_i,

  input  wire                d_ready_i,
  output logic               d_valid_o,
  output tl_d_op_e           d_opcode_o,
  output logic [`BUS_DW-1:0] d_data_o,
  output logic               d_error_o
);

  localparam int unsigned IDX_W = $clog2(`MEM_WORDS);

  logic [`BUS_DW-1:0] mem [`MEM_WORDS];
  logic [IDX_W-1:0]   idx;
  logic               is_get;
  logic               full_bad;
  logic               wr_en;

  // word index, byte offset dropped
  assign idx      = addr_i[IDX_W+1:2];
  assign is_get   = (opcode_i == OP_GET);
  // a full put must carry every byte lane
  assign full_bad = (opcode_i == OP_PUT_FULL) && (mask_i != '1);
  assign wr_en    = req_i & ~is_get & ~full_bad;

  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int b = 0; b < `BUS_MW; b++) begin
        if (mask_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // response stays up until d_ready
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_valid_o <= 1'b0;
    end else if (req_i) begin
      d_valid_o <= 1'b1;
    end else if (d_ready_i) begin
      d_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (req_i) begin
      d_opcode_o <= is_get ? OP_ACK_DATA : OP_ACK;
      d_data_o   <= is_get ? mem[idx] : '0;
      d_error_o  <= full_bad;
    end
  end

endmodule

`default_nettype wire

//--- design/gpio.sv
`default_nettype none

`include "soc_cfg.svh"

module gpio import soc_pkg::*; (
  input  wire                clock,
  input  wire                arst_n_i,

  input  wire                req_i,
  input  wire tl_a_op_e      opcode_i,
  input  wire [`BUS_AW-1:0]  addr_i,
  input  wire [`BUS_DW-1:0]  wdata_i,

  input  wire                d_ready_i,
  output logic               d_valid_o,
  output tl_d_op_e           d_opcode_o,
  output logic [`BUS_DW-1:0] d_data_o,
  output logic               d_error_o,

  // pad side
  input  wire [`GPIO_W-1:0]  gpio_in_i,
  output logic [`GPIO_W-1:0] gpio_out_o,
  output logic [`GPIO_W-1:0] gpio_oe_o,
  output logic               intr_o
);

  logic [`BUS_AW-1:0] offset;
  logic               is_get;
  logic               reg_known;
  logic               wr_en;
  logic [`BUS_DW-1:0] rd_data;

  logic [`GPIO_W-1:0] data_out_q;
  logic [`GPIO_W-1:0] dir_q;
  logic [`GPIO_W-1:0] intr_en_q;
  logic [`GPIO_W-1:0] intr_state_q;
  logic [`GPIO_W-1:0] sync_q;
  logic [`GPIO_W-1:0] data_in_q;
  logic [`GPIO_W-1:0] data_in_prev_q;
  logic [`GPIO_W-1:0] rise;
  logic [`GPIO_W-1:0] intr_clr;

  assign offset = addr_i - `GPIO_BASE;
  assign is_get = (opcode_i == OP_GET);

  // register read mux, unknown offsets flagged
  always_comb begin
    reg_known = 1'b1;
    rd_data   = '0;
    case (offset)
      `GPIO_DATA_IN:    rd_data = `BUS_DW'(data_in_q);
      `GPIO_DATA_OUT:   rd_data = `BUS_DW'(data_out_q);
      `GPIO_DIR:        rd_data = `BUS_DW'(dir_q);
      `GPIO_INTR_EN:    rd_data = `BUS_DW'(intr_en_q);
      `GPIO_INTR_STATE: rd_data = `BUS_DW'(intr_state_q);
      default:          reg_known = 1'b0;
    endcase
  end

  assign wr_en = req_i & ~is_get & reg_known;

  // writes to DATA_IN fall through with no effect
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_out_q <= '0;
      dir_q      <= '0;
      intr_en_q  <= '0;
    end else if (wr_en) begin
      if (offset == `GPIO_DATA_OUT) begin
        data_out_q <= wdata_i[`GPIO_W-1:0];
      end
      if (offset == `GPIO_DIR) begin
        dir_q <= wdata_i[`GPIO_W-1:0];
      end
      if (offset == `GPIO_INTR_EN) begin
        intr_en_q <= wdata_i[`GPIO_W-1:0];
      end
    end
  end

  // two-flop synchronizer, then one more stage for edge detect
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q         <= '0;
      data_in_q      <= '0;
      data_in_prev_q <= '0;
    end else begin
      sync_q         <= gpio_in_i;
      data_in_q      <= sync_q;
      data_in_prev_q <= data_in_q;
    end
  end

  assign rise     = data_in_q & ~data_in_prev_q;
  assign intr_clr = (wr_en && offset == `GPIO_INTR_STATE) ? wdata_i[`GPIO_W-1:0] : '0;

  // write one to clear; a new edge wins over the clear
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      intr_state_q <= '0;
    end else begin
      intr_state_q <= (intr_state_q & ~intr_clr) | rise;
    end
  end

  assign intr_o     = |(intr_state_q & intr_en_q);
  assign gpio_out_o = data_out_q;
  assign gpio_oe_o  = dir_q;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_valid_o <= 1'b0;
    end else if (req_i) begin
      d_valid_o <= 1'b1;
    end else if (d_ready_i) begin
      d_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (req_i) begin
      d_opcode_o <= is_get ? OP_ACK_DATA : OP_ACK;
      d_data_o   <= is_get ? rd_data : '0;
      d_error_o  <= ~reg_known;
    end
  end

endmodule

`default_nettype wire

//--- design/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// host bus widths
`define BUS_AW 32
`define BUS_DW 32
`define BUS_MW 4

// pad count
`define GPIO_W 20

// address map
`define MEM_BASE  32'h0000_0000
`define MEM_WORDS 256
`define GPIO_BASE 32'h4000_0000
`define GPIO_SPAN 32

// gpio register offsets from GPIO_BASE
`define GPIO_DATA_IN    32'h0000_0000
`define GPIO_DATA_OUT   32'h0000_0004
`define GPIO_DIR        32'h0000_0008
`define GPIO_INTR_EN    32'h0000_000C
`define GPIO_INTR_STATE 32'h0000_0010

`endif

//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // request opcodes, TL-UL channel A encoding
  typedef enum logic [2:0] {
    OP_PUT_FULL    = 3'h0,
    OP_PUT_PARTIAL = 3'h1,
    OP_GET         = 3'h4
  } tl_a_op_e;

  // response opcodes, TL-UL channel D encoding
  typedef enum logic [2:0] {
    OP_ACK      = 3'h0,
    OP_ACK_DATA = 3'h1
  } tl_d_op_e;

  // decoded target of a request
  typedef enum logic [1:0] {
    DEV_MEM  = 2'd0,
    DEV_GPIO = 2'd1,
    DEV_NONE = 2'd2
  } dev_sel_e;

endpackage

`default_nettype wire

//--- design/soc_top.sv
`default_nettype none

`include "soc_cfg.svh"

module soc_top import soc_pkg::*; (
  input  wire                clock,
  input  wire                arst_n_i,

  // host request channel
  input  wire                a_valid_i,
  output logic               a_ready_o,
  input  wire tl_a_op_e      a_opcode_i,
  input  wire [`BUS_AW-1:0]  a_address_i,
  input  wire [`BUS_DW-1:0]  a_data_i,
  input  wire [`BUS_MW-1:0]  a_mask_i,

  // host response channel
  output logic               d_valid_o,
  input  wire                d_ready_i,
  output tl_d_op_e           d_opcode_o,
  output logic [`BUS_DW-1:0] d_data_o,
  output logic               d_error_o,

  output logic               intr_o,
  inout  wire [`GPIO_W-1:0]  gpio_io
);

  logic               mem_req;
  logic               gpio_req;
  logic               rsp_done;

  logic               mem_valid;
  tl_d_op_e           mem_opcode;
  logic [`BUS_DW-1:0] mem_data;
  logic               mem_error;

  logic               gpio_valid;
  tl_d_op_e           gpio_opcode;
  logic [`BUS_DW-1:0] gpio_data;
  logic               gpio_error;

  logic               err_valid;
  tl_d_op_e           err_opcode;

  logic [`GPIO_W-1:0] gpio_in;
  logic [`GPIO_W-1:0] gpio_out;
  logic [`GPIO_W-1:0] gpio_oe;

  bus_decode u_decode (
    .clock        (clock),
    .arst_n_i     (arst_n_i),
    .a_valid_i    (a_valid_i),
    .a_ready_o    (a_ready_o),
    .a_opcode_i   (a_opcode_i),
    .a_address_i  (a_address_i),
    .rsp_done_i   (rsp_done),
    .mem_req_o    (mem_req),
    .gpio_req_o   (gpio_req),
    .err_valid_o  (err_valid),
    .err_opcode_o (err_opcode),
    .d_ready_i    (d_ready_i)
  );

  // targets share the request payload straight from the host
  data_mem u_dmem (
    .clock      (clock),
    .arst_n_i   (arst_n_i),
    .req_i      (mem_req),
    .opcode_i   (a_opcode_i),
    .addr_i     (a_address_i),
    .wdata_i    (a_data_i),
    .mask_i     (a_mask_i),
    .d_ready_i  (d_ready_i),
    .d_valid_o  (mem_valid),
    .d_opcode_o (mem_opcode),
    .d_data_o   (mem_data),
    .d_error_o  (mem_error)
  );

  gpio u_gpio (
    .clock      (clock),
    .arst_n_i   (arst_n_i),
    .req_i      (gpio_req),
    .opcode_i   (a_opcode_i),
    .addr_i     (a_address_i),
    .wdata_i    (a_data_i),
    .d_ready_i  (d_ready_i),
    .d_valid_o  (gpio_valid),
    .d_opcode_o (gpio_opcode),
    .d_data_o   (gpio_data),
    .d_error_o  (gpio_error),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_oe_o  (gpio_oe),
    .intr_o     (intr_o)
  );

  bus_resp_mux u_resp (
    .mem_valid_i   (mem_valid),
    .mem_opcode_i  (mem_opcode),
    .mem_data_i    (mem_data),
    .mem_error_i   (mem_error),
    .gpio_valid_i  (gpio_valid),
    .gpio_opcode_i (gpio_opcode),
    .gpio_data_i   (gpio_data),
    .gpio_error_i  (gpio_error),
    .err_valid_i   (err_valid),
    .err_opcode_i  (err_opcode),
    .d_ready_i     (d_ready_i),
    .d_valid_o     (d_valid_o),
    .d_opcode_o    (d_opcode_o),
    .d_data_o      (d_data_o),
    .d_error_o     (d_error_o),
    .rsp_done_o    (rsp_done)
  );

  // pads read back whatever is on the wire
  assign gpio_in = gpio_io;

  for (genvar i = 0; i < `GPIO_W; i++) begin : g_pad
    assign gpio_io[i] = gpio_oe[i] ? gpio_out[i] : 1'bz;
  end

endmodule

`default_nettype wire

//--- dv/soc_props.sv
`default_nettype none

`include "soc_cfg.svh"

module soc_props import soc_pkg::*; (
  input  wire                clock,
  input  wire                arst_n_i,
  input  wire                a_valid_i,
  input  wire                a_ready_i,
  input  wire                d_valid_i,
  input  wire                d_ready_i,
  input  wire tl_d_op_e      d_opcode_i,
  input  wire [`BUS_DW-1:0]  d_data_i,
  input  wire                d_error_i
);

  // response frozen while the host stalls
  rsp_stable: assert property (@(posedge clock) disable iff (!arst_n_i)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_data_i) &&
                                $stable(d_opcode_i) && $stable(d_error_i))
    else $error("response changed before d_ready");

  // one outstanding transaction
  no_ready_pending: assert property (@(posedge clock) disable iff (!arst_n_i)
    d_valid_i |-> !a_ready_i)
    else $error("a_ready high while a response is pending");

  rsp_latency: assert property (@(posedge clock) disable iff (!arst_n_i)
    a_valid_i && a_ready_i |=> d_valid_i)
    else $error("no response one cycle after the request fired");

endmodule

bind soc_top soc_props u_props (
  .clock      (clock),
  .arst_n_i   (arst_n_i),
  .a_valid_i  (a_valid_i),
  .a_ready_i  (a_ready_o),
  .d_valid_i  (d_valid_o),
  .d_ready_i  (d_ready_i),
  .d_opcode_i (d_opcode_o),
  .d_data_i   (d_data_o),
  .d_error_i  (d_error_o)
);

`default_nettype wire

//--- dv/soc_tb.sv
`default_nettype none

`include "soc_cfg.svh"

module soc_tb import soc_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int HS_LIMIT     = 20;
  // budget of transactions times their length plus idle waits
  localparam int N_XFERS      = 48;
  localparam int XFER_CYCLES  = 4;
  localparam int WAIT_CYCLES  = 40;
  localparam int TIMEOUT      =
    (RESET_CYCLES + N_XFERS * XFER_CYCLES + WAIT_CYCLES) * CLK_PERIOD * 2;
  localparam logic [`BUS_AW-1:0] NO_DEV_ADDR     = 32'h2000_0000;
  localparam logic [`BUS_AW-1:0] GPIO_ALIAS_ADDR = `GPIO_BASE + 32'h0100_0000 + `GPIO_DIR;

  logic               clock;
  logic               arst_n_i;
  logic               a_valid_i;
  logic               a_ready_o;
  tl_a_op_e           a_opcode_i;
  logic [`BUS_AW-1:0] a_address_i;
  logic [`BUS_DW-1:0] a_data_i;
  logic [`BUS_MW-1:0] a_mask_i;
  logic               d_valid_o;
  logic               d_ready_i;
  tl_d_op_e           d_opcode_o;
  logic [`BUS_DW-1:0] d_data_o;
  logic               d_error_o;
  logic               intr_o;
  wire  [`GPIO_W-1:0] gpio_io;

  int                 errors = 0;
  integer             seed   = 32'hc09a;
  logic [`BUS_DW-1:0] mem_model [`MEM_WORDS];
  int                 mem_idx [8];
  logic [`GPIO_W-1:0] dir_model;
  logic [`GPIO_W-1:0] pad_val;
  logic [`GPIO_W-1:0] pad_en;
  // last response seen by the host
  logic [`BUS_DW-1:0] rsp_data;
  tl_d_op_e           rsp_op;
  logic               rsp_err;

  soc_top dut (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_opcode_i  (a_opcode_i),
    .a_address_i (a_address_i),
    .a_data_i    (a_data_i),
    .a_mask_i    (a_mask_i),
    .d_valid_o   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_opcode_o  (d_opcode_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o),
    .intr_o      (intr_o),
    .gpio_io     (gpio_io)
  );

  // external pad drivers on pins the DUT treats as inputs
  for (genvar i = 0; i < `GPIO_W; i++) begin : g_pad_drv
    assign gpio_io[i] = (pad_en[i] && !dir_model[i]) ? pad_val[i] : 1'bz;
  end

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #2;
    end
  endtask

  task automatic check_data(input string name, input logic [`BUS_DW-1:0] exp,
                            input logic [`BUS_DW-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_op(input string name, input tl_d_op_e exp, input tl_d_op_e act);
    if (act !== exp) begin
      $display("FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected error %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  function automatic logic [`BUS_DW-1:0] merge_bytes(input logic [`BUS_DW-1:0] old_word,
                                                     input logic [`BUS_DW-1:0] new_word,
                                                     input logic [`BUS_MW-1:0] mask);
    logic [`BUS_DW-1:0] res;
    res = old_word;
    for (int b = 0; b < `BUS_MW; b++) begin
      if (mask[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // one full host transaction with d_ready stalled for hold cycles
  task automatic host_xfer(input tl_a_op_e op, input logic [`BUS_AW-1:0] addr,
                           input logic [`BUS_DW-1:0] data, input logic [`BUS_MW-1:0] mask,
                           input int hold);
    int                 wait_cnt;
    logic [`BUS_DW-1:0] held_data;
    d_ready_i   = (hold == 0);
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_address_i = addr;
    a_data_i    = data;
    a_mask_i    = mask;
    wait_cnt    = 0;
    while (!a_ready_o && wait_cnt < HS_LIMIT) begin
      wait_cycles(1);
      wait_cnt++;
    end
    if (!a_ready_o) begin
      $display("request to %h was never accepted", addr);
      errors++;
      a_valid_i = 1'b0;
      d_ready_i = 1'b1;
      return;
    end
    wait_cycles(1);
    a_valid_i = 1'b0;
    wait_cnt  = 0;
    while (!d_valid_o && wait_cnt < HS_LIMIT) begin
      wait_cycles(1);
      wait_cnt++;
    end
    if (!d_valid_o) begin
      $display("no response arrived for request to %h", addr);
      errors++;
      d_ready_i = 1'b1;
      return;
    end
    held_data = d_data_o;
    for (int c = 0; c < hold; c++) begin
      wait_cycles(1);
      check_bit("stall d_valid", 1'b1, d_valid_o);
      check_data("stall d_data", held_data, d_data_o);
      check_bit("stall a_ready", 1'b0, a_ready_o);
    end
    rsp_data  = d_data_o;
    rsp_op    = d_opcode_o;
    rsp_err   = d_error_o;
    d_ready_i = 1'b1;
    wait_cycles(1);
  endtask

  task automatic bus_put(input tl_a_op_e op, input logic [`BUS_AW-1:0] addr,
                         input logic [`BUS_DW-1:0] data, input logic [`BUS_MW-1:0] mask);
    host_xfer(op, addr, data, mask, 0);
  endtask

  task automatic bus_get(input logic [`BUS_AW-1:0] addr, input int hold);
    host_xfer(OP_GET, addr, '0, '1, hold);
  endtask

  task automatic reset_values();
    check_bit("reset a_ready", 1'b1, a_ready_o);
    check_bit("reset d_valid", 1'b0, d_valid_o);
    check_bit("reset intr", 1'b0, intr_o);
    check_data("reset pads", `BUS_DW'(20'bz), `BUS_DW'(gpio_io));
  endtask

  task automatic mem_access();
    logic [`BUS_DW-1:0] wdata;
    logic [`BUS_MW-1:0] mask;
    logic [`BUS_AW-1:0] addr;
    for (int i = 0; i < 8; i++) begin
      mem_idx[i] = {$random(seed)} % `MEM_WORDS;
      wdata      = $random(seed);
      bus_put(OP_PUT_FULL, `MEM_BASE + `BUS_AW'(mem_idx[i]) * 4, wdata, '1);
      mem_model[mem_idx[i]] = wdata;
      check_op("mem put full op", OP_ACK, rsp_op);
      check_err("mem put full err", 1'b0, rsp_err);
    end
    for (int i = 0; i < 8; i++) begin
      wdata = $random(seed);
      mask  = $random(seed);
      bus_put(OP_PUT_PARTIAL, `MEM_BASE + `BUS_AW'(mem_idx[i]) * 4, wdata, mask);
      mem_model[mem_idx[i]] = merge_bytes(mem_model[mem_idx[i]], wdata, mask);
      check_op("mem put partial op", OP_ACK, rsp_op);
      check_err("mem put partial err", 1'b0, rsp_err);
    end
    for (int i = 0; i < 8; i++) begin
      bus_get(`MEM_BASE + `BUS_AW'(mem_idx[i]) * 4, 0);
      check_op("mem get op", OP_ACK_DATA, rsp_op);
      check_data("mem get data", mem_model[mem_idx[i]], rsp_data);
      check_err("mem get err", 1'b0, rsp_err);
    end
    // full put with lanes missing is refused
    addr = `MEM_BASE + `BUS_AW'(mem_idx[0]) * 4;
    bus_put(OP_PUT_FULL, addr, ~mem_model[mem_idx[0]], 4'b0011);
    check_err("mem bad full put err", 1'b1, rsp_err);
    bus_get(addr, 0);
    check_data("mem after bad put", mem_model[mem_idx[0]], rsp_data);
  endtask

  task automatic unmapped_access();
    bus_get(NO_DEV_ADDR, 0);
    check_err("unmapped get err", 1'b1, rsp_err);
    check_data("unmapped get data", '0, rsp_data);
    check_op("unmapped get op", OP_ACK_DATA, rsp_op);
    // low bits alias a written memory word
    bus_put(OP_PUT_FULL, NO_DEV_ADDR + `BUS_AW'(mem_idx[0]) * 4, 32'hdead_beef, '1);
    check_err("unmapped put err", 1'b1, rsp_err);
    check_op("unmapped put op", OP_ACK, rsp_op);
    check_data("unmapped put data", '0, rsp_data);
    bus_get(`MEM_BASE + `BUS_AW'(mem_idx[0]) * 4, 0);
    check_data("mem after unmapped put", mem_model[mem_idx[0]], rsp_data);
    // low bits alias the DIR register outside the GPIO window
    bus_put(OP_PUT_FULL, GPIO_ALIAS_ADDR, 32'hdead_beef, '1);
    check_err("unmapped gpio alias err", 1'b1, rsp_err);
    bus_get(`GPIO_BASE + `GPIO_DIR, 0);
    check_data("gpio dir after unmapped put", `BUS_DW'(dir_model), rsp_data);
  endtask

  task automatic gpio_pads();
    logic [`GPIO_W-1:0] dir;
    logic [`GPIO_W-1:0] dout;
    dir  = $random(seed);
    dout = $random(seed);
    bus_put(OP_PUT_FULL, `GPIO_BASE + `GPIO_DIR, `BUS_DW'(dir), '1);
    dir_model = dir;
    bus_put(OP_PUT_FULL, `GPIO_BASE + `GPIO_DATA_OUT, `BUS_DW'(dout), '1);
    check_err("gpio data_out put err", 1'b0, rsp_err);
    check_data("gpio driven pads", `BUS_DW'(dout & dir), `BUS_DW'(gpio_io & dir));
    pad_val = $random(seed);
    pad_en  = '1;
    wait_cycles(3);
    bus_get(`GPIO_BASE + `GPIO_DATA_IN, 0);
    check_op("gpio data_in op", OP_ACK_DATA, rsp_op);
    check_data("gpio data_in", `BUS_DW'((dout & dir) | (pad_val & ~dir)), rsp_data);
  endtask

  task automatic intr_edges();
    int wait_cnt;
    pad_val = '0;
    bus_put(OP_PUT_FULL, `GPIO_BASE + `GPIO_DIR, '0, '1);
    dir_model = '0;
    wait_cycles(4);
    bus_put(OP_PUT_FULL, `GPIO_BASE + `GPIO_INTR_STATE, '1, '1);
    bus_put(OP_PUT_FULL, `GPIO_BASE + `GPIO_INTR_EN, 32'h0000_0020, '1);
    check_bit("intr before edge", 1'b0, intr_o);
    pad_val[5] = 1'b1;
    wait_cnt   = 0;
    while (!intr_o && wait_cnt < 5) begin
      wait_cycles(1);
      wait_cnt++;
    end
    if (!intr_o) begin
      $display("intr_o did not rise within 5 cycles of the edge on pad 5");
      errors++;
    end
    bus_get(`GPIO_BASE + `GPIO_INTR_STATE, 0);
    check_data("intr_state after edge", 32'h0000_0020, rsp_data);
    bus_put(OP_PUT_FULL, `GPIO_BASE + `GPIO_INTR_STATE, 32'h0000_0020, '1);
    check_bit("intr after clear", 1'b0, intr_o);
    // edge on a pin with its enable off
    pad_val[9] = 1'b1;
    wait_cycles(6);
    check_bit("intr on disabled pin", 1'b0, intr_o);
    bus_get(`GPIO_BASE + `GPIO_INTR_STATE, 0);
    check_data("intr_state disabled pin", 32'h0000_0200, rsp_data);
  endtask

  task automatic backpressure_hold();
    logic [`BUS_DW-1:0] wdata;
    wdata = $random(seed);
    bus_put(OP_PUT_FULL, `MEM_BASE + `BUS_AW'(mem_idx[1]) * 4, wdata, '1);
    mem_model[mem_idx[1]] = wdata;
    bus_get(`MEM_BASE + `BUS_AW'(mem_idx[1]) * 4, 5);
    check_op("stalled get op", OP_ACK_DATA, rsp_op);
    check_data("stalled get data", wdata, rsp_data);
    check_bit("a_ready after release", 1'b1, a_ready_o);
  endtask

  initial begin
    #(TIMEOUT);
    $display("watchdog expired after %0d time units, tests did not finish", TIMEOUT);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    clock       = 1'b0;
    arst_n_i    = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = OP_GET;
    a_address_i = '0;
    a_data_i    = '0;
    a_mask_i    = '0;
    d_ready_i   = 1'b1;
    dir_model   = '0;
    pad_val     = '0;
    pad_en      = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    arst_n_i = 1'b1;
    wait_cycles(1);
    reset_values();
    mem_access();
    unmapped_access();
    gpio_pads();
    intr_edges();
    backpressure_hold();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/soc_pkg.sv
design/bus_decode.sv
design/data_mem.sv
design/gpio.sv
design/bus_resp_mux.sv
design/soc_top.sv
dv/soc_props.sv
dv/soc_tb.sv
